// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sparcControlUnitTb
FILELIST ?= sparcControlUnit.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/controlEncoder.sv ====
`timescale 1ns/10ps
`include "sparcCtrl_cfg.svh"

module controlEncoder (
	input sparcCtrlPkg::ctrlState_t state,
	input sparcCtrlPkg::instrFields_t fields,
	input logic mfc,
	output sparcCtrlPkg::ctrlWord_t ctrl
);

	always_comb
	begin
		ctrl = '0; // Strobes and register addresses low
		ctrl.extenderSelect = `SPARC_EXT_SIMM13;
		ctrl.pcInSelect = `SPARC_PCIN_NPC;
		ctrl.aluASelect = `SPARC_ALUA_REG;
		ctrl.aluBSelect = `SPARC_ALUB_REG;
		ctrl.mdrSelect = `SPARC_MDR_ALU;
		ctrl.aluOp = `SPARC_OP3_ADD;
		ctrl.ramOpCode = `SPARC_OP3_LD; // Word load for fetch

		// Operand routing per state
		case (state)
			sparcCtrlPkg::resetNpc:
			begin
				ctrl.aluASelect = `SPARC_ALUA_PC; // Cleared PC + 4
				ctrl.aluBSelect = `SPARC_ALUB_FOUR;
			end
			sparcCtrlPkg::fetchAddr,
			sparcCtrlPkg::fetchMar: ctrl.aluBSelect = `SPARC_ALUB_PC; // r0 + PC
			sparcCtrlPkg::pcAdvance, sparcCtrlPkg::pcStep,
			sparcCtrlPkg::annulSetup, sparcCtrlPkg::annulNpc,
			sparcCtrlPkg::annulPc, sparcCtrlPkg::annulNpcLast,
			sparcCtrlPkg::skipPc, sparcCtrlPkg::skipNpc:
			begin
				ctrl.aluASelect = `SPARC_ALUA_NPC; // nPC + 4 for nPC, nPC for PC
				ctrl.aluBSelect = `SPARC_ALUB_FOUR;
			end
			sparcCtrlPkg::sethiSetup, sparcCtrlPkg::sethiWrite:
			begin
				ctrl.extenderSelect = `SPARC_EXT_SETHI;
				ctrl.aluBSelect = `SPARC_ALUB_EXT;
				ctrl.regC = fields.rd;
			end
			sparcCtrlPkg::aluSetup, sparcCtrlPkg::aluWrite,
			sparcCtrlPkg::memAddr, sparcCtrlPkg::memMar:
			begin
				ctrl.regA = fields.rs1;
				if (fields.immSelect)
					ctrl.aluBSelect = `SPARC_ALUB_EXT; // simm13
				else
					ctrl.regB = fields.rs2;
				if (state == sparcCtrlPkg::aluSetup || state == sparcCtrlPkg::aluWrite)
				begin
					ctrl.aluOp = fields.op3;
					ctrl.regC = fields.rd;
				end
			end
			sparcCtrlPkg::loadRam,
			sparcCtrlPkg::loadMdr: ctrl.mdrSelect = `SPARC_MDR_RAM;
			sparcCtrlPkg::loadWrite:
			begin
				ctrl.aluBSelect = `SPARC_ALUB_MDR; // r0 + MDR
				ctrl.regC = fields.rd;
			end
			sparcCtrlPkg::storeData,
			sparcCtrlPkg::storeMdr: ctrl.regA = fields.rd; // rd + r0 into MDR
			sparcCtrlPkg::callLink:
			begin
				ctrl.aluBSelect = `SPARC_ALUB_PC;
				ctrl.regC = `SPARC_LINK_REG;
			end
			sparcCtrlPkg::callTarget, sparcCtrlPkg::callNpc:
			begin
				ctrl.regA = `SPARC_LINK_REG; // r15 holds the CALL address
				ctrl.extenderSelect = `SPARC_EXT_DISP30;
				ctrl.aluBSelect = `SPARC_ALUB_EXT;
			end
			sparcCtrlPkg::branchTarget, sparcCtrlPkg::branchStep:
			begin
				ctrl.aluASelect = `SPARC_ALUA_PC;
				ctrl.extenderSelect = `SPARC_EXT_DISP22;
				ctrl.aluBSelect = `SPARC_ALUB_EXT;
			end
			default: ;
		endcase

		if (state inside {sparcCtrlPkg::memAddr, sparcCtrlPkg::memMar, sparcCtrlPkg::loadRam,
			sparcCtrlPkg::loadMdr, sparcCtrlPkg::loadWrite, sparcCtrlPkg::storeData,
			sparcCtrlPkg::storeMdr, sparcCtrlPkg::storeRam})
			ctrl.ramOpCode = fields.op3; // Access size from the instruction

		// One-cycle strobes, RAM ones span the wait
		case (state)
			sparcCtrlPkg::resetInit: ctrl.pcClr = 1'b1;
			sparcCtrlPkg::fetchMar,
			sparcCtrlPkg::memMar: ctrl.marEnable = 1'b1;
			sparcCtrlPkg::fetchWait:
			begin
				ctrl.ramEnable = 1'b1;
				ctrl.irEnable = mfc; // IR captures on completion
			end
			sparcCtrlPkg::loadRam,
			sparcCtrlPkg::storeRam: ctrl.ramEnable = 1'b1;
			sparcCtrlPkg::loadMdr,
			sparcCtrlPkg::storeMdr: ctrl.mdrEnable = 1'b1;
			sparcCtrlPkg::sethiWrite,
			sparcCtrlPkg::loadWrite: ctrl.regWrite = 1'b1;
			sparcCtrlPkg::aluWrite:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.psrEnable = fields.setCc; // Only the cc forms touch icc
			end
			sparcCtrlPkg::callLink:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.pcEnable = 1'b1; // Delay slot PC, same cycle as link write
			end
			sparcCtrlPkg::pcStep,
			sparcCtrlPkg::branchStep:
			begin
				ctrl.pcEnable = 1'b1;
				ctrl.npcEnable = 1'b1;
			end
			sparcCtrlPkg::resetNpc, sparcCtrlPkg::callNpc, sparcCtrlPkg::annulNpc,
			sparcCtrlPkg::annulNpcLast, sparcCtrlPkg::skipNpc: ctrl.npcEnable = 1'b1;
			sparcCtrlPkg::annulPc,
			sparcCtrlPkg::skipPc: ctrl.pcEnable = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/10ps
`include "sparcCtrl_cfg.svh"

module instrDecoder (
	input logic [`SPARC_WORD_W-1:0] ir,
	output sparcCtrlPkg::instrClass_t instrClass,
	output sparcCtrlPkg::instrFields_t fields
);

	sparcCtrlPkg::instrFormat_t irFmt;
	logic [2:0] op2; // Format 2 sub-opcode
	logic [`SPARC_OP3_W-1:0] op3Base; // op3 without the cc bit
	logic isAluOp;
	logic isLoad;
	logic isStore;

	assign irFmt = ir;
	assign op2 = irFmt.op3[`SPARC_OP3_W-1 -: 3];

	always_comb
	begin
		op3Base = irFmt.op3;
		op3Base[`SPARC_OP3_CC_BIT] = 1'b0; // addcc matches add etc
	end

	// Opcode lists of the kept instructions
	assign isAluOp = (op3Base inside {`SPARC_OP3_ADD, `SPARC_OP3_ADDX, `SPARC_OP3_SUB,
		`SPARC_OP3_SUBX, `SPARC_OP3_AND, `SPARC_OP3_ANDN, `SPARC_OP3_OR, `SPARC_OP3_ORN,
		`SPARC_OP3_XOR, `SPARC_OP3_XNOR})
		|| (irFmt.op3 inside {`SPARC_OP3_SLL, `SPARC_OP3_SRL, `SPARC_OP3_SRA});
	assign isLoad = irFmt.op3 inside {`SPARC_OP3_LD, `SPARC_OP3_LDUB, `SPARC_OP3_LDUH,
		`SPARC_OP3_LDSB, `SPARC_OP3_LDSH};
	assign isStore = irFmt.op3 inside {`SPARC_OP3_ST, `SPARC_OP3_STB, `SPARC_OP3_STH};

	always_comb
	begin
		instrClass = sparcCtrlPkg::classNop; // Anything unknown just advances
		case (irFmt.op)
			`SPARC_OP_BRANCH:
			begin
				if (op2 == `SPARC_OP2_SETHI)
					instrClass = sparcCtrlPkg::classSethi;
				else if (op2 == `SPARC_OP2_BICC)
					instrClass = sparcCtrlPkg::classBranch;
			end
			`SPARC_OP_CALL: instrClass = sparcCtrlPkg::classCall;
			`SPARC_OP_ARITH:
			begin
				if (isAluOp)
					instrClass = sparcCtrlPkg::classAlu;
			end
			`SPARC_OP_MEM:
			begin
				if (isLoad)
					instrClass = sparcCtrlPkg::classLoad;
				else if (isStore)
					instrClass = sparcCtrlPkg::classStore;
			end
		endcase
	end

	assign fields.rd = irFmt.rd;
	assign fields.rs1 = irFmt.rs1;
	assign fields.rs2 = irFmt.rs2;
	assign fields.op3 = irFmt.op3;
	assign fields.immSelect = irFmt.immFlag;
	assign fields.setCc = irFmt.op3[`SPARC_OP3_CC_BIT];
	assign fields.annul = irFmt.rd[`SPARC_REG_W-1]; // ir[29]

endmodule

// ==== rtl/sparcControlUnit.sv ====
`timescale 1ns/10ps
`include "sparcCtrl_cfg.svh"

module sparcControlUnit (
	input logic Clk,
	input logic RESET,
	input logic [`SPARC_WORD_W-1:0] ir, // Instruction register contents
	input logic mfc,
	input logic condTrue, // Branch condition from icc
	input logic branchAlways,
	input logic branchNever,
	output sparcCtrlPkg::ctrlWord_t ctrl
);

	sparcCtrlPkg::instrClass_t instrClass;
	sparcCtrlPkg::instrFields_t fields;
	sparcCtrlPkg::ctrlState_t state;

	instrDecoder instrDecoder_inst (
		.ir(ir),
		.instrClass(instrClass),
		.fields(fields)
	);

	stateSequencer stateSequencer_inst (
		.Clk(Clk),
		.RESET(RESET),
		.instrClass(instrClass),
		.annul(fields.annul),
		.mfc(mfc),
		.condTrue(condTrue),
		.branchAlways(branchAlways),
		.branchNever(branchNever),
		.state(state)
	);

	// Moore decode of the state plus the fetch mfc term
	controlEncoder controlEncoder_inst (
		.state(state),
		.fields(fields),
		.mfc(mfc),
		.ctrl(ctrl)
	);

endmodule

// ==== rtl/sparcCtrlPkg.sv ====
`include "sparcCtrl_cfg.svh"

package sparcCtrlPkg;

	// Format 3 view of the instruction word
	typedef struct packed {
		logic [1:0] op;
		logic [`SPARC_REG_W-1:0] rd; // Top bit is the annul bit in Bicc
		logic [`SPARC_OP3_W-1:0] op3; // Top three bits are op2 in format 2
		logic [`SPARC_REG_W-1:0] rs1;
		logic immFlag;
		logic [7:0] asi; // Not decoded
		logic [`SPARC_REG_W-1:0] rs2;
	} instrFormat_t;

	typedef enum logic [2:0] {
		classNop, // Illegal or dropped, acts as a no-op
		classSethi,
		classBranch,
		classCall,
		classAlu,
		classLoad,
		classStore
	} instrClass_t;

	// Fields pulled out once by the decoder
	typedef struct packed {
		logic [`SPARC_REG_W-1:0] rd;
		logic [`SPARC_REG_W-1:0] rs1;
		logic [`SPARC_REG_W-1:0] rs2;
		logic [`SPARC_OP3_W-1:0] op3;
		logic immSelect; // simm13 instead of rs2
		logic setCc;
		logic annul;
	} instrFields_t;

	typedef enum logic [7:0] {
		resetIdle, resetInit, resetNpc, // Held in resetIdle while RESET is high
		fetchAddr, fetchMar, fetchWait, decode,
		pcAdvance, pcStep, // Sequential PC <- nPC, nPC <- nPC + 4
		sethiSetup, sethiWrite,
		aluSetup, aluWrite,
		memAddr, memMar, // Shared address phase of loads and stores
		loadRam, loadMdr, loadWrite,
		storeData, storeMdr, storeRam,
		callLink, callTarget, callNpc,
		branchResolve, branchTarget, branchStep,
		annulSetup, annulNpc, annulPc, annulNpcLast,
		skipPc, skipNpc // Not taken, delay slot executes
	} ctrlState_t;

	typedef struct packed {
		logic irEnable;
		logic npcEnable;
		logic pcEnable;
		logic mdrEnable;
		logic marEnable;
		logic regWrite;
		logic ramEnable;
		logic psrEnable;
		logic pcClr;
		logic [`SPARC_EXT_SEL_W-1:0] extenderSelect;
		logic [`SPARC_PCIN_SEL_W-1:0] pcInSelect;
		logic [`SPARC_ALUA_SEL_W-1:0] aluASelect;
		logic [`SPARC_ALUB_SEL_W-1:0] aluBSelect;
		logic mdrSelect;
		logic [`SPARC_REG_W-1:0] regC; // Write port
		logic [`SPARC_REG_W-1:0] regA;
		logic [`SPARC_REG_W-1:0] regB;
		logic [`SPARC_OP3_W-1:0] aluOp;
		logic [`SPARC_OP3_W-1:0] ramOpCode;
	} ctrlWord_t;

endpackage

// ==== rtl/sparcCtrl_cfg.svh ====
`ifndef SPARC_CTRL_CFG_SVH
`define SPARC_CTRL_CFG_SVH

`define SPARC_WORD_W 32 // Instruction and data width
`define SPARC_REG_W 5
`define SPARC_OP3_W 6
`define SPARC_OP3_CC_BIT 4 // Set in op3 when the ALU op writes icc
`define SPARC_LINK_REG 5'd15 // CALL return address lands here

// Mux select widths
`define SPARC_EXT_SEL_W 3
`define SPARC_PCIN_SEL_W 2
`define SPARC_ALUA_SEL_W 2
`define SPARC_ALUB_SEL_W 4

// Select codes, the first of each group is the hold code
`define SPARC_ALUA_REG 2'b00 // Register file port A
`define SPARC_ALUA_PC 2'b01
`define SPARC_ALUA_NPC 2'b10
`define SPARC_ALUB_REG 4'b0000 // Register file port B
`define SPARC_ALUB_EXT 4'b0001 // Sign extender / shifter
`define SPARC_ALUB_MDR 4'b0010
`define SPARC_ALUB_PC 4'b0011
`define SPARC_ALUB_FOUR 4'b0110 // Constant 4
`define SPARC_EXT_SIMM13 3'b000
`define SPARC_EXT_DISP30 3'b011 // disp30 times 4
`define SPARC_EXT_SETHI 3'b100 // imm22 into the upper bits
`define SPARC_EXT_DISP22 3'b101 // disp22 times 4
`define SPARC_PCIN_NPC 2'b00
`define SPARC_MDR_ALU 1'b0
`define SPARC_MDR_RAM 1'b1

// Top level op field
`define SPARC_OP_BRANCH 2'b00 // Format 2, sethi and Bicc
`define SPARC_OP_CALL 2'b01
`define SPARC_OP_ARITH 2'b10
`define SPARC_OP_MEM 2'b11
`define SPARC_OP2_BICC 3'b010
`define SPARC_OP2_SETHI 3'b100

// Arithmetic and logic op3, cc bit clear
`define SPARC_OP3_ADD 6'b000000
`define SPARC_OP3_ADDX 6'b001000
`define SPARC_OP3_SUB 6'b000100
`define SPARC_OP3_SUBX 6'b001100
`define SPARC_OP3_AND 6'b000001
`define SPARC_OP3_ANDN 6'b000101
`define SPARC_OP3_OR 6'b000010
`define SPARC_OP3_ORN 6'b000110
`define SPARC_OP3_XOR 6'b000011
`define SPARC_OP3_XNOR 6'b000111
`define SPARC_OP3_SLL 6'b100101 // Shifts have no cc form
`define SPARC_OP3_SRL 6'b100110
`define SPARC_OP3_SRA 6'b100111

// Loads and stores
`define SPARC_OP3_LD 6'b000000 // Word load, also used for fetch
`define SPARC_OP3_LDUB 6'b000001
`define SPARC_OP3_LDUH 6'b000010
`define SPARC_OP3_LDSB 6'b001001
`define SPARC_OP3_LDSH 6'b001010
`define SPARC_OP3_ST 6'b000100
`define SPARC_OP3_STB 6'b000101
`define SPARC_OP3_STH 6'b000110

`endif

// ==== rtl/stateSequencer.sv ====
`timescale 1ns/10ps

module stateSequencer (
	input logic Clk,
	input logic RESET,
	input sparcCtrlPkg::instrClass_t instrClass,
	input logic annul,
	input logic mfc, // Memory function complete
	input logic condTrue,
	input logic branchAlways,
	input logic branchNever,
	output sparcCtrlPkg::ctrlState_t state
);

	sparcCtrlPkg::ctrlState_t nextState;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= sparcCtrlPkg::resetIdle; // All strobes quiet here
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state; // mfc waits hold by default
		case (state)
			sparcCtrlPkg::resetIdle: nextState = sparcCtrlPkg::resetInit;
			sparcCtrlPkg::resetInit: nextState = sparcCtrlPkg::resetNpc;
			sparcCtrlPkg::resetNpc: nextState = sparcCtrlPkg::fetchAddr;

			// Fetch
			sparcCtrlPkg::fetchAddr: nextState = sparcCtrlPkg::fetchMar;
			sparcCtrlPkg::fetchMar: nextState = sparcCtrlPkg::fetchWait;
			sparcCtrlPkg::fetchWait:
			begin
				if (mfc)
					nextState = sparcCtrlPkg::decode; // IR loads in this same cycle
			end

			// Class dispatch
			sparcCtrlPkg::decode:
			begin
				case (instrClass)
					sparcCtrlPkg::classSethi: nextState = sparcCtrlPkg::sethiSetup;
					sparcCtrlPkg::classBranch: nextState = sparcCtrlPkg::branchResolve;
					sparcCtrlPkg::classCall: nextState = sparcCtrlPkg::callLink;
					sparcCtrlPkg::classAlu: nextState = sparcCtrlPkg::aluSetup;
					sparcCtrlPkg::classLoad,
					sparcCtrlPkg::classStore: nextState = sparcCtrlPkg::memAddr;
					default: nextState = sparcCtrlPkg::pcAdvance; // No-op
				endcase
			end

			sparcCtrlPkg::pcAdvance: nextState = sparcCtrlPkg::pcStep;
			sparcCtrlPkg::pcStep: nextState = sparcCtrlPkg::fetchAddr;

			sparcCtrlPkg::sethiSetup: nextState = sparcCtrlPkg::sethiWrite;
			sparcCtrlPkg::sethiWrite: nextState = sparcCtrlPkg::pcAdvance;

			sparcCtrlPkg::aluSetup: nextState = sparcCtrlPkg::aluWrite;
			sparcCtrlPkg::aluWrite: nextState = sparcCtrlPkg::pcAdvance;

			// Loads and stores split after MAR is loaded
			sparcCtrlPkg::memAddr: nextState = sparcCtrlPkg::memMar;
			sparcCtrlPkg::memMar:
			begin
				if (instrClass == sparcCtrlPkg::classLoad)
					nextState = sparcCtrlPkg::loadRam;
				else
					nextState = sparcCtrlPkg::storeData;
			end
			sparcCtrlPkg::loadRam:
			begin
				if (mfc)
					nextState = sparcCtrlPkg::loadMdr;
			end
			sparcCtrlPkg::loadMdr: nextState = sparcCtrlPkg::loadWrite;
			sparcCtrlPkg::loadWrite: nextState = sparcCtrlPkg::pcAdvance;
			sparcCtrlPkg::storeData: nextState = sparcCtrlPkg::storeMdr;
			sparcCtrlPkg::storeMdr: nextState = sparcCtrlPkg::storeRam;
			sparcCtrlPkg::storeRam:
			begin
				if (mfc)
					nextState = sparcCtrlPkg::pcAdvance;
			end

			// CALL sets nPC itself, so no PC advance
			sparcCtrlPkg::callLink: nextState = sparcCtrlPkg::callTarget;
			sparcCtrlPkg::callTarget: nextState = sparcCtrlPkg::callNpc;
			sparcCtrlPkg::callNpc: nextState = sparcCtrlPkg::fetchAddr;

			// Four branch paths
			sparcCtrlPkg::branchResolve:
			begin
				if (annul && (branchAlways || branchNever || !condTrue))
					nextState = sparcCtrlPkg::annulSetup; // Delay slot skipped
				else if (branchNever)
					nextState = sparcCtrlPkg::pcAdvance;
				else if (condTrue)
					nextState = sparcCtrlPkg::branchTarget;
				else
					nextState = sparcCtrlPkg::skipPc;
			end
			sparcCtrlPkg::branchTarget: nextState = sparcCtrlPkg::branchStep;
			sparcCtrlPkg::branchStep: nextState = sparcCtrlPkg::fetchAddr;
			sparcCtrlPkg::annulSetup: nextState = sparcCtrlPkg::annulNpc;
			sparcCtrlPkg::annulNpc: nextState = sparcCtrlPkg::annulPc;
			sparcCtrlPkg::annulPc: nextState = sparcCtrlPkg::annulNpcLast;
			sparcCtrlPkg::annulNpcLast: nextState = sparcCtrlPkg::fetchAddr;
			sparcCtrlPkg::skipPc: nextState = sparcCtrlPkg::skipNpc;
			sparcCtrlPkg::skipNpc: nextState = sparcCtrlPkg::fetchAddr;

			default: nextState = sparcCtrlPkg::resetInit; // Unused codes restart
		endcase
	end

endmodule

// ==== sparcControlUnit.f ====
+incdir+rtl
rtl/sparcCtrlPkg.sv
rtl/instrDecoder.sv
rtl/stateSequencer.sv
rtl/controlEncoder.sv
rtl/sparcControlUnit.sv
tb/tbClock.sv
tb/sparcControlUnitTb.sv

// ==== tb/sparcControlUnitTb.sv ====
`timescale 1ns/10ps
`include "sparcCtrl_cfg.svh"

module sparcControlUnitTb;

	localparam int irBit = 8; // Positions in the strobe vector
	localparam int npcBit = 7;
	localparam int mdrBit = 5;
	localparam int marBit = 4;
	localparam int regBit = 3;
	localparam int ramBit = 2;
	localparam int waitLimit = 200; // Cycles before a wait gives up

	logic Clk;
	logic RESET;
	logic [`SPARC_WORD_W-1:0] ir;
	logic mfc = 1'b0;
	logic condTrue;
	logic branchAlways;
	logic branchNever;
	sparcCtrlPkg::ctrlWord_t ctrl;

	sparcCtrlPkg::ctrlWord_t trace[$]; // One entry per rising edge
	logic mfcTrace[$];
	logic [31:0] lfsrState = 32'h7949b595;
	int errorCount = 0;
	int testCount = 0;
	int failCount = 0;
	int testStartErrors;
	int delayCount;
	logic ramBusy = 1'b0;

	tbClock tbClock_inst (.Clk(Clk), .RESET(RESET));

	sparcControlUnit sparcControlUnit_inst (
		.Clk(Clk), .RESET(RESET), .ir(ir), .mfc(mfc), .condTrue(condTrue),
		.branchAlways(branchAlways), .branchNever(branchNever), .ctrl(ctrl)
	);

	function automatic logic [8:0] strobes(input sparcCtrlPkg::ctrlWord_t c);
		return {c.irEnable, c.npcEnable, c.pcEnable, c.mdrEnable, c.marEnable,
			c.regWrite, c.ramEnable, c.psrEnable, c.pcClr};
	endfunction

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hA3000000; // Taps 32, 30, 26, 25
		return n;
	endfunction

	function automatic logic nextBit();
		lfsrState = galoisStep(lfsrState);
		return lfsrState[0];
	endfunction

	// Sample on the rising edge, values from the cycle just ending
	always @(posedge Clk)
	begin
		if (!RESET)
		begin
			trace.push_back(ctrl);
			mfcTrace.push_back(mfc);
		end
	end

	// Memory responder, mfc after 1 to 4 cycles of ramEnable
	always @(negedge Clk)
	begin
		if (RESET || !ctrl.ramEnable)
		begin
			mfc <= 1'b0;
			ramBusy = 1'b0;
		end
		else if (!ramBusy)
		begin
			ramBusy = 1'b1;
			delayCount = 1 + int'({nextBit(), nextBit()});
			mfc <= (delayCount == 1);
		end
		else if (!mfc)
		begin
			delayCount--;
			mfc <= (delayCount == 1);
		end
	end

	// Strobes stay quiet during reset
	resetQuiet: assert property (@(posedge Clk) RESET |-> strobes(ctrl) == 9'b0)
		else
		begin
			errorCount++;
			$display("Strobe active during reset at %0t", $time);
		end
	ramHold: assert property (@(posedge Clk) disable iff (RESET)
		ctrl.ramEnable && !mfc |=> ctrl.ramEnable)
		else
		begin
			errorCount++;
			$display("ramEnable dropped before mfc at %0t", $time);
		end
	irOnMfc: assert property (@(posedge Clk) disable iff (RESET)
		ctrl.irEnable |-> ctrl.ramEnable && mfc && ctrl.ramOpCode == `SPARC_OP3_LD)
		else
		begin
			errorCount++;
			$display("irEnable outside a completed word fetch at %0t", $time);
		end
	clrAlone: assert property (@(posedge Clk) disable iff (RESET)
		ctrl.pcClr |-> strobes(ctrl) == 9'b1)
		else
		begin
			errorCount++;
			$display("pcClr shared its cycle with another strobe at %0t", $time);
		end

	function automatic int findStrobe(input int from, input int bitIdx);
		logic [8:0] s;
		for (int i = from; i < trace.size(); i++)
		begin
			s = strobes(trace[i]);
			if (s[bitIdx])
				return i;
		end
		return -1;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finishRun();
		$display("%0d tests, %0d passed, %0d failed, %0d errors", testCount,
			testCount - failCount, failCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount != testStartErrors)
		begin
			failCount++;
			$display("%s: failed", name);
		end
		else
			$display("%s: passed", name);
		testStartErrors = errorCount;
	endtask

	// Counts marEnable cycles seen at falling edges
	task automatic waitForMar(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles <= waitLimit)
		begin
			@(negedge Clk);
			cycles++;
			if (ctrl.marEnable)
				seen++;
		end
		if (seen < count)
		begin
			errorCount++;
			$display("Timed out waiting for marEnable at %0t", $time);
			finishRun();
		end
	endtask

	// ramEnable must hold until mfc, ramOpCode fixed throughout
	task automatic checkRamRun(input int from, input logic [5:0] op, output int last);
		int i;
		i = findStrobe(from, ramBit);
		assert (i >= 0) else
		begin
			errorCount++;
			$display("No RAM access found at %0t", $time);
		end
		last = i;
		while (i >= 0 && i < trace.size())
		begin
			checkEq("ramEnable", 32'(trace[i].ramEnable), 32'd1);
			checkEq("ramOpCode", 32'(trace[i].ramOpCode), 32'(op));
			last = i;
			if (mfcTrace[i])
				break;
			i++;
		end
	endtask

	// Called at the fetch marEnable; returns the decode index
	task automatic runInstr(input logic [31:0] instr, input int marCount, output int dec);
		int iEnd;
		ir = instr;
		trace.delete();
		mfcTrace.delete();
		waitForMar(marCount);
		// Last entry is the fetchAddr of the next instruction
		checkEq("fetch aluBSelect", 32'(trace[trace.size() - 1].aluBSelect),
			32'(`SPARC_ALUB_PC));
		checkRamRun(0, `SPARC_OP3_LD, iEnd);
		checkEq("irEnable", 32'(trace[iEnd].irEnable), 32'd1);
		checkEq("irEnable position", 32'(findStrobe(0, irBit)), 32'(iEnd));
		dec = iEnd + 1;
	endtask

	// PC strobe codes after decode, 2 for pc, 1 for npc, 3 for both
	task automatic checkPcPulses(input int dec, input int expected[$]);
		int got[$];
		for (int i = dec + 1; i < trace.size(); i++)
			if (trace[i].pcEnable || trace[i].npcEnable)
				got.push_back(int'({trace[i].pcEnable, trace[i].npcEnable}));
		checkEq("PC pulse count", 32'(got.size()), 32'(expected.size()));
		for (int i = 0; i < got.size() && i < expected.size(); i++)
			checkEq("PC pulse code", 32'(got[i]), 32'(expected[i]));
	endtask

	function automatic logic [31:0] aluInstr(input logic [1:0] op, input logic [4:0] rd,
		input logic [5:0] op3, input logic [4:0] rs1, input logic imm, input logic [4:0] rs2);
		return {op, rd, op3, rs1, imm, 8'h2a, rs2};
	endfunction

	task automatic aluTest(input logic [4:0] rd, input logic [5:0] op3, input logic imm);
		int dec;
		logic [31:0] instr;
		instr = aluInstr(`SPARC_OP_ARITH, rd, op3, 5'd3, imm, 5'd17);
		runInstr(instr, 1, dec);
		checkEq("regWrite", 32'(trace[dec + 2].regWrite), 32'd1);
		checkEq("regC", 32'(trace[dec + 2].regC), 32'(rd));
		checkEq("aluOp", 32'(trace[dec + 2].aluOp), 32'(op3));
		checkEq("regA", 32'(trace[dec + 2].regA), 32'd3);
		checkEq("aluBSelect", 32'(trace[dec + 1].aluBSelect),
			imm ? 32'(`SPARC_ALUB_EXT) : 32'(`SPARC_ALUB_REG));
		if (imm)
		begin
			assert (trace[dec + 2].regB != 5'd17) else
			begin
				errorCount++;
				$display("Fail at %0t: regB is %h, expected other than %h", $time,
					trace[dec + 2].regB, 5'd17);
			end
		end
		else
			checkEq("regB", 32'(trace[dec + 2].regB), 32'd17);
		checkEq("psrEnable", 32'(trace[dec + 2].psrEnable), 32'(op3[4]));
		checkEq("pcEnable", 32'(trace[dec + 4].pcEnable), 32'd1);
		checkEq("npcEnable", 32'(trace[dec + 4].npcEnable), 32'd1);
		checkPcPulses(dec, '{3});
		endTest($sformatf("alu op3 %b imm %0d", op3, imm));
	endtask

	task automatic memTest(input logic isLoad, input logic [5:0] op3, input logic [4:0] rd);
		int dec;
		int mar;
		int mdr;
		int ramEnd;
		runInstr(aluInstr(`SPARC_OP_MEM, rd, op3, 5'd2, 1'b1, 5'd8), 2, dec);
		mar = findStrobe(dec, marBit);
		checkEq("marEnable after decode", 32'(mar > dec), 32'd1);
		checkRamRun(dec, op3, ramEnd);
		mdr = findStrobe(dec, mdrBit);
		if (isLoad)
		begin
			checkEq("RAM follows MAR", 32'(findStrobe(dec, ramBit)), 32'(mar + 1));
			checkEq("mdrEnable position", 32'(mdr), 32'(ramEnd + 1));
			checkEq("regWrite position", 32'(findStrobe(dec, regBit)), 32'(mdr + 1));
			checkEq("regC", 32'(trace[mdr + 1].regC), 32'(rd));
		end
		else
		begin
			checkEq("mdrEnable order", 32'(mdr > mar && mdr < ramEnd), 32'd1);
			checkEq("regA", 32'(trace[mdr].regA), 32'(rd));
			checkEq("RAM follows MDR", 32'(findStrobe(dec, ramBit)), 32'(mdr + 1));
			checkEq("store regWrite", 32'(findStrobe(dec, regBit)), 32'hffffffff);
		end
		checkPcPulses(dec, '{3});
		endTest(isLoad ? "load" : "store");
	endtask

	task automatic branchTest(input logic [3:0] combo);
		int dec;
		int expected[$];
		logic annul;
		logic taken;
		logic annulled;
		annul = combo[3];
		condTrue = combo[0];
		branchAlways = combo[1];
		branchNever = combo[2];
		// Taken needs annul clear or a conditional branch
		taken = condTrue && !branchNever && (!annul || !branchAlways);
		annulled = annul && (branchAlways || branchNever || !condTrue);
		if (taken)
			expected = '{3}; // PC and nPC together after the target
		else if (annulled)
			expected = '{1, 2, 1}; // Delay slot skipped
		else if (branchNever)
			expected = '{3}; // Plain PC advance
		else
			expected = '{2, 1};
		runInstr({2'b00, annul, 4'h0, `SPARC_OP2_BICC, 22'h000010}, 1, dec);
		checkPcPulses(dec, expected);
		endTest($sformatf("branch annul %b never %b always %b cond %b", combo[3],
			combo[2], combo[1], combo[0]));
	endtask

	initial
	begin
		int dec;
		ir = '0;
		condTrue = 1'b0;
		branchAlways = 1'b0;
		branchNever = 1'b0;
		testStartErrors = 0;

		waitForMar(1);
		checkEq("pcClr", 32'(trace[1].pcClr), 32'd1);
		checkEq("npcEnable position", 32'(findStrobe(0, npcBit)), 32'd2);
		checkEq("marEnable position", 32'(trace.size()), 32'd4); // Cycle not yet traced
		endTest("reset");

		for (int n = 0; n < 6; n++)
		begin
			runInstr(aluInstr(`SPARC_OP_ARITH, 5'd4, 6'b111000, 5'd1, 1'b0, 5'd2), 1, dec);
			checkPcPulses(dec, '{3}); // Dropped JMPL, PC advance only
			checkEq("regWrite", 32'(findStrobe(dec, regBit)), 32'hffffffff);
		end
		endTest("fetch and unsupported opcode");

		aluTest(5'd5, `SPARC_OP3_OR, 1'b0);
		aluTest(5'd6, 6'b010000, 1'b1); // addcc
		aluTest(5'd9, 6'b010100, 1'b0); // subcc
		aluTest(5'd12, `SPARC_OP3_XOR, 1'b1);
		memTest(1'b1, `SPARC_OP3_LDUB, 5'd7);
		memTest(1'b1, `SPARC_OP3_LD, 5'd21);
		memTest(1'b0, `SPARC_OP3_STH, 5'd9);
		for (int c = 0; c < 16; c++)
			branchTest(4'(c));
		condTrue = 1'b0;
		branchAlways = 1'b0;
		branchNever = 1'b0;

		runInstr({2'b00, 5'd13, `SPARC_OP2_SETHI, 22'h2bcde}, 1, dec);
		checkEq("regWrite", 32'(trace[dec + 2].regWrite), 32'd1);
		checkEq("regC", 32'(trace[dec + 2].regC), 32'd13);
		endTest("sethi");

		runInstr({`SPARC_OP_CALL, 30'h00000040}, 1, dec);
		checkEq("regWrite", 32'(trace[dec + 1].regWrite), 32'd1);
		checkEq("pcEnable", 32'(trace[dec + 1].pcEnable), 32'd1);
		checkEq("regC", 32'(trace[dec + 1].regC), 32'd15);
		checkPcPulses(dec, '{2, 1});
		endTest("call");

		finishRun();
	end

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic Clk,
	output logic RESET
);

	initial
	begin
		Clk = 1'b0;
		forever
			#5 Clk = ~Clk; // 10 ns period
	end

	initial
	begin
		RESET = 1'b1;
		repeat (3) @(negedge Clk); // Three rising edges see RESET high
		RESET = 1'b0;
	end

endmodule
